// ==== tb.f ====
+incdir+.
fb_pkg.sv
write_coalescer.sv
write_req_queue.sv
fb_write_path.sv
tb_mem_port.sv
tb_fb_write_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_fb_write_path
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)

run: build
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_fb_write_path.sv ====
`timescale 1ns/100ps
`include "fb_settings.svh"

module tb_fb_write_path import fb_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 500;
    localparam int SETTLE     = 12;
    localparam int SEED       = 95952;

    logic     clk_in;
    logic     rst_in;
    pixel_t   pixel_in;
    logic     pixel_valid;
    logic     pixel_ready;
    logic     frame;
    mem_req_t mem_req;
    logic     mem_valid;
    logic     mem_credit;
    logic     hold_credits;

    // reference model of the open word
    logic [`FB_ADDR_W-1:0] m_addr;
    mem_word_t             m_data;
    logic [15:0]           m_strobe;
    logic [7:0]            m_written;
    mem_req_t              exp_q [$];

    string cur_test;
    int    base;
    int    tests;
    int    checks;
    int    errors;
    int    test_errors;

    fb_write_path i_fb_write_path (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .frame       (frame),
        .mem_req     (mem_req),
        .mem_valid   (mem_valid),
        .mem_credit  (mem_credit)
    );

    tb_mem_port i_mem_port (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .mem_req      (mem_req),
        .mem_valid    (mem_valid),
        .hold_credits (hold_credits),
        .mem_credit   (mem_credit)
    );

    initial clk_in = 1'b0;
    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic pixel_t make_pixel(input int h, input int v,
                                          input logic [15:0] color, input logic mask);
        pixel_t p;
        p.hcount    = `FB_HCOUNT_W'(h);
        p.vcount    = `FB_VCOUNT_W'(v);
        p.color     = color;
        p.mask_zero = mask;
        return p;
    endfunction

    task automatic model_close();
        mem_req_t r;
        if (m_written != 0) begin
            r.addr   = m_addr;
            r.data   = m_data;
            r.strobe = m_strobe;
            exp_q.push_back(r);
        end
        m_written = '0;
    endtask

    task automatic model_pixel(input pixel_t p);
        int pa;
        int lane;
        logic [`FB_ADDR_W-1:0] w;
        pa   = int'(p.hcount) + `FB_HRES * int'(p.vcount);
        w    = `FB_ADDR_W'(pa / 8);
        lane = pa % 8;
        if (m_written != 0 && w != m_addr) begin
            model_close();
        end
        if (m_written == 0) begin
            m_addr   = w;
            m_data   = '0;
            m_strobe = '0;
        end
        // a lane is two bytes, low byte first
        m_data.bytes[2 * lane]     = p.color[7:0];
        m_data.bytes[2 * lane + 1] = p.color[15:8];
        m_strobe[2 * lane]         = !p.mask_zero;
        m_strobe[2 * lane + 1]     = !p.mask_zero;
        m_written[lane]            = 1'b1;
        if (&m_written) begin
            model_close();
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_pixel(input pixel_t p);
        int waited;
        pixel_in    = p;
        pixel_valid = 1'b1;
        waited      = 0;
        while (!pixel_ready && waited < TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        if (!pixel_ready) begin
            $display("Timeout in %s: pixel at h %0d v %0d was never accepted",
                     cur_test, p.hcount, p.vcount);
            test_errors++;
        end else begin
            @(negedge clk_in);
            model_pixel(p);
        end
        pixel_valid = 1'b0;
    endtask

    task automatic send_frame();
        int waited;
        frame  = 1'b1;
        waited = 0;
        while (!pixel_ready && waited < TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        if (!pixel_ready) begin
            $display("Timeout in %s: frame pulse was never accepted", cur_test);
            test_errors++;
        end else begin
            @(negedge clk_in);
            model_close();
        end
        frame = 1'b0;
    endtask

    task automatic check_requests();
        int waited;
        int got_n;
        mem_req_t got;
        waited = 0;
        while (i_mem_port.received.size() < base + exp_q.size() && waited < TIMEOUT) begin
            @(posedge clk_in);
            waited++;
        end
        if (i_mem_port.received.size() < base + exp_q.size()) begin
            $display("Timeout in %s: only %0d of %0d requests reached memory", cur_test,
                     i_mem_port.received.size() - base, exp_q.size());
            test_errors++;
        end
        // a quiet stretch shows up any extra request
        repeat (SETTLE) @(posedge clk_in);
        got_n = i_mem_port.received.size() - base;
        checks++;
        assert (got_n == exp_q.size()) else begin
            $display("Error %s: expected %0d requests, actual %0d", cur_test, exp_q.size(), got_n);
            test_errors++;
        end
        for (int k = 0; k < exp_q.size() && k < got_n; k++) begin
            got = i_mem_port.received[base + k];
            checks++;
            assert (got === exp_q[k]) else begin
                $display("Error %s: request %0d expected %h/%h/%h, actual %h/%h/%h", cur_test, k,
                         exp_q[k].addr, exp_q[k].data, exp_q[k].strobe,
                         got.addr, got.data, got.strobe);
                test_errors++;
            end
        end
        base += got_n;
        exp_q.delete();
        @(negedge clk_in);
    endtask

    task automatic finish_test();
        $display("test %-13s done, %0d errors", cur_test, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    task automatic test_full_word();
        cur_test = "full_word";
        // h 16 on row 2 starts word 82
        for (int h = 16; h < 24; h++) begin
            send_pixel(make_pixel(h, 2, 16'h1000 + 16'(h), 1'b0));
        end
        check_requests();
        finish_test();
    endtask

    task automatic test_partial_run();
        cur_test = "partial_run";
        for (int h = 12; h < 16; h++) begin
            send_pixel(make_pixel(h, 3, 16'h2300 + 16'(h), 1'b0));
        end
        for (int h = 13; h < 15; h++) begin
            send_pixel(make_pixel(h, 5, 16'h2500 + 16'(h), 1'b0));
        end
        // jump to another row closes the half word
        send_pixel(make_pixel(0, 6, 16'h2600, 1'b0));
        send_frame();
        check_requests();
        finish_test();
    endtask

    task automatic test_masked_lanes();
        cur_test = "masked_lanes";
        send_pixel(make_pixel(0, 10, 16'h3000, 1'b0));
        send_pixel(make_pixel(1, 10, 16'h3001, 1'b1));
        send_pixel(make_pixel(2, 10, 16'h3002, 1'b0));
        send_pixel(make_pixel(2, 10, 16'h3bad, 1'b0));
        send_pixel(make_pixel(3, 10, 16'h3003, 1'b1));
        send_pixel(make_pixel(5, 10, 16'h3005, 1'b0));
        send_frame();
        // word with only a masked lane, strobe stays zero
        send_pixel(make_pixel(8, 20, 16'h3fff, 1'b1));
        send_frame();
        check_requests();
        finish_test();
    endtask

    task automatic test_frame_flush();
        cur_test = "frame_flush";
        for (int h = 100; h < 103; h++) begin
            send_pixel(make_pixel(h, 7, 16'h4000 + 16'(h), 1'b0));
        end
        send_frame();
        send_frame();
        check_requests();
        finish_test();
    endtask

    task automatic test_backpressure();
        int stalled;
        int waited;
        cur_test = "backpressure";
        @(posedge clk_in);
        hold_credits = 1'b1;
        @(negedge clk_in);
        fork
            begin
                // eight full words, more than credits plus queue
                for (int i = 0; i < 64; i++) begin
                    send_pixel(make_pixel(i, 40, 16'h5000 + 16'(i), 1'b0));
                end
            end
            begin
                stalled = 0;
                waited  = 0;
                while (stalled < 10 && waited < TIMEOUT) begin
                    @(negedge clk_in);
                    stalled = pixel_ready ? 0 : stalled + 1;
                    waited++;
                end
                if (stalled < 10) begin
                    $display("Timeout in %s: pixel_ready never dropped with credits held",
                             cur_test);
                    test_errors++;
                end
                @(posedge clk_in);
                checks++;
                assert (i_mem_port.received.size() - base <= `FB_MEM_CREDITS) else begin
                    $display("Error %s: expected at most %0d requests, actual %0d", cur_test,
                             `FB_MEM_CREDITS, i_mem_port.received.size() - base);
                    test_errors++;
                end
                hold_credits = 1'b0;
            end
        join
        check_requests();
        finish_test();
    endtask

    task automatic test_random_runs();
        int len;
        int h;
        int v;
        cur_test = "random_runs";
        for (int r = 0; r < 24; r++) begin
            len = 1 + int'($urandom % 12);
            v   = int'($urandom % `FB_VRES);
            h   = int'($urandom % (`FB_HRES - len + 1));
            for (int i = 0; i < len; i++) begin
                send_pixel(make_pixel(h + i, v, 16'($urandom), ($urandom % 4) == 0));
            end
        end
        send_frame();
        check_requests();
        finish_test();
    endtask

    initial begin
        rst_in       = 1'b1;
        pixel_in     = '0;
        pixel_valid  = 1'b0;
        frame        = 1'b0;
        hold_credits = 1'b0;
        m_addr       = '0;
        m_data       = '0;
        m_strobe     = '0;
        m_written    = '0;
        base         = 0;
        tests        = 0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        void'($urandom(SEED));

        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);

        test_full_word();
        test_partial_run();
        test_masked_lanes();
        test_frame_flush();
        test_backpressure();
        test_random_runs();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb_mem_port.sv ====
`timescale 1ns/100ps
`include "fb_settings.svh"

module tb_mem_port import fb_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  mem_req_t mem_req,
    input  logic     mem_valid,
    input  logic     hold_credits,
    output logic     mem_credit
);

    // cycles from a request to its credit
    localparam int CREDIT_DELAY = 4;

    // every request seen on the port, in arrival order
    mem_req_t    received [$];
    int unsigned due [$];
    int unsigned cycle;

    initial begin
        mem_credit = 1'b0;
        cycle      = 0;
        forever begin
            @(negedge clk_in);
            cycle      = cycle + 1;
            mem_credit = 1'b0;
            if (rst_in) begin
                due.delete();
            end else begin
                if (mem_valid) begin
                    received.push_back(mem_req);
                    due.push_back(cycle + CREDIT_DELAY);
                end
                // held credits pile up and drain one per cycle later
                if (!hold_credits && due.size() > 0 && due[0] <= cycle) begin
                    due.delete(0);
                    mem_credit = 1'b1;
                end
            end
        end
    end

endmodule

// ==== fb_write_path.sv ====
`timescale 1ns/100ps

module fb_write_path import fb_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  pixel_t   pixel_in,
    input  logic     pixel_valid,
    output logic     pixel_ready,
    input  logic     frame,
    output mem_req_t mem_req,
    output logic     mem_valid,
    input  logic     mem_credit
);

    // coalescer to queue
    logic     push;
    mem_req_t push_req;
    logic     full;

    write_coalescer i_write_coalescer (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .frame       (frame),
        .full        (full),
        .push        (push),
        .push_req    (push_req)
    );

    // credit flow toward memory
    write_req_queue i_write_req_queue (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .push       (push),
        .push_req   (push_req),
        .full       (full),
        .mem_req    (mem_req),
        .mem_valid  (mem_valid),
        .mem_credit (mem_credit)
    );

endmodule

// ==== write_req_queue.sv ====
`timescale 1ns/100ps
`include "fb_settings.svh"

module write_req_queue import fb_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     push,
    input  mem_req_t push_req,
    output logic     full,
    output mem_req_t mem_req,
    output logic     mem_valid,
    input  logic     mem_credit
);

    // depth is a power of two so pointers wrap on their own
    mem_req_t                           entries [`FB_QUEUE_DEPTH];
    logic [$clog2(`FB_QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`FB_QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`FB_QUEUE_DEPTH):0]   count;
    logic [$clog2(`FB_MEM_CREDITS):0]   credits;
    logic                               empty;
    logic                               issue;

    assign empty = (count == 0);
    assign full  = (count == `FB_QUEUE_DEPTH);

    // head goes out as soon as memory holds room for it
    assign issue = !empty && (credits != 0);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= `FB_MEM_CREDITS;
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= issue;

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // one credit per issue, one back per pulse
            case ({mem_credit, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
        if (issue) begin
            mem_req <= entries[rd_ptr];
        end
    end

    // memory never returns more than it granted
    assert property (@(posedge clk_in) disable iff (rst_in) credits <= `FB_MEM_CREDITS)
        else $error("write_req_queue credit count above the reset grant");

    // every request on the port was covered by a credit
    assert property (@(posedge clk_in) disable iff (rst_in)
        mem_valid |-> $past(credits) != 0)
        else $error("write_req_queue issued a request without a credit");

endmodule

// ==== write_coalescer.sv ====
`timescale 1ns/100ps
`include "fb_settings.svh"

module write_coalescer import fb_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  pixel_t   pixel_in,
    input  logic     pixel_valid,
    output logic     pixel_ready,
    input  logic     frame,
    input  logic     full,
    output logic     push,
    output mem_req_t push_req
);

    // open word
    logic [`FB_ADDR_W-1:0] cur_addr;
    mem_word_t             cur_data;
    logic [15:0]           cur_strobe;
    logic [7:0]            cur_written;
    logic                  cur_masked;
    logic                  word_open;

    // incoming pixel position
    logic [`FB_PIX_W-1:0]  pix_addr;
    logic [`FB_ADDR_W-1:0] pix_word;
    logic [2:0]            pix_lane;

    logic                  ready_en;
    logic                  accept;
    logic                  frame_acc;
    logic                  foreign;
    logic                  fresh;
    logic                  close_old;
    logic                  close_new;

    // open word after merging the incoming pixel
    mem_word_t             mrg_data;
    logic [15:0]           mrg_strobe;
    logic [7:0]            mrg_written;
    logic                  mrg_masked;

    logic                  push_masked;

    assign pix_addr = `FB_PIX_W'(pixel_in.hcount)
                    + `FB_PIX_W'(`FB_HRES) * `FB_PIX_W'(pixel_in.vcount);
    assign pix_word = pix_addr[`FB_PIX_W-1:3];
    assign pix_lane = pix_addr[2:0];

    assign word_open = |cur_written;

    // stall while a word goes out or the queue is full
    assign pixel_ready = ready_en && !push && !full;
    assign accept      = pixel_valid && pixel_ready;
    assign frame_acc   = frame && pixel_ready;

    assign foreign = word_open && (pix_word != cur_addr);

    // a pixel that comes with the frame pulse starts the next word
    assign fresh = !word_open || frame_acc || foreign;

    assign close_old = word_open && (frame_acc || (accept && foreign));
    assign close_new = accept && (&mrg_written);

    always_comb begin
        mrg_data    = fresh ? '0 : cur_data;
        mrg_strobe  = fresh ? '0 : cur_strobe;
        mrg_written = fresh ? '0 : cur_written;
        mrg_masked  = fresh ? 1'b0 : cur_masked;

        // later pixel on the same lane overwrites data and strobe
        mrg_data.lane[pix_lane]          = pixel_in.color;
        mrg_strobe[{pix_lane, 1'b0} +: 2] = {2{!pixel_in.mask_zero}};
        mrg_written[pix_lane]            = 1'b1;
        mrg_masked                       = mrg_masked || pixel_in.mask_zero;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ready_en    <= 1'b0;
            push        <= 1'b0;
            cur_written <= '0;
        end else begin
            ready_en <= 1'b1;
            push     <= close_old || close_new;

            if (accept) begin
                // a full word leaves now and nothing stays open
                cur_written <= close_new ? '0 : mrg_written;
            end else if (frame_acc) begin
                cur_written <= '0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            cur_addr   <= pix_word;
            cur_data   <= mrg_data;
            cur_strobe <= mrg_strobe;
            cur_masked <= mrg_masked;
        end

        if (close_old) begin
            push_req.addr   <= cur_addr;
            push_req.data   <= cur_data;
            push_req.strobe <= cur_strobe;
            push_masked     <= cur_masked;
        end else if (close_new) begin
            push_req.addr   <= pix_word;
            push_req.data   <= mrg_data;
            push_req.strobe <= mrg_strobe;
            push_masked     <= mrg_masked;
        end
    end

    // queue must have room for every word we send
    assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full)
        else $error("write_coalescer pushed into a full queue");

    // empty strobe only if some lane was written masked
    assert property (@(posedge clk_in) disable iff (rst_in)
        push |-> (push_req.strobe != '0) || push_masked)
        else $error("write_coalescer pushed a word with no strobe and no masked lane");

endmodule

// ==== fb_pkg.sv ====
`include "fb_settings.svh"

package fb_pkg;

    // one pixel from the rasterizer
    typedef struct packed {
        logic [`FB_HCOUNT_W-1:0] hcount;
        logic [`FB_VCOUNT_W-1:0] vcount;
        logic [15:0]             color;
        logic                    mask_zero;
    } pixel_t;

    // lanes for the coalescer and bytes for the memory port
    typedef union packed {
        logic [7:0][15:0] lane;
        logic [15:0][7:0] bytes;
    } mem_word_t;

    // strobe bit n enables data byte n
    typedef struct packed {
        logic [`FB_ADDR_W-1:0] addr;
        mem_word_t             data;
        logic [15:0]           strobe;
    } mem_req_t;

endpackage

// ==== fb_settings.svh ====
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// screen size in pixels
`define FB_HRES 320
`define FB_VRES 180

// widths of the raster counters
`define FB_HCOUNT_W 9
`define FB_VCOUNT_W 8

// linear pixel address covers HRES*VRES pixels
`define FB_PIX_W 16
// word address drops the three lane bits
`define FB_ADDR_W 13

// write request entries held before memory
`define FB_QUEUE_DEPTH 4

// credits granted by the memory port after reset
`define FB_MEM_CREDITS 2

`endif
